// File: list.f
src/rv_pkg.sv
src/rv_ctrl_if.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_imm_gen.sv
src/rv_main_fsm.sv
src/rv_datapath.sv
src/rv_core.sv
dv/rv_core_asserts.sv
dv/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module tb_rv_core -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation failed"; exit 1; }

// File: dv/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        mem_valid;
    logic        mem_ready;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    logic [31:0] mem [1024];     // memory seen by the DUT
    logic [31:0] ref_mem [1024]; // private copy for the reference model
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] obs_addr [$];
    logic [31:0] obs_data [$];
    int          seed;
    int          pw;     // next program word
    int          st_off; // next result slot above x10

    // branch table where even entries are taken and odd ones fall through
    localparam int br_f3 [12]  = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    localparam int br_rs1 [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
    localparam int br_rs2 [12] = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};

    rv_core #(
        .reset_vector (32'h0)
    ) rv_core_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[pw] = word;
        pw++;
    endtask

    task automatic emit_store(input int rs);
        emit(enc_s(st_off, rs, 10));
        st_off += 4;
    endtask

    task automatic build_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h3c6e_f372;
        end
        pw = 0;
        st_off = 0;
        emit(enc_i(1024, 0, 0, 10, 7'h13)); // result area at x10 = 0x800
        emit(enc_r(0, 10, 10, 0, 10));
        emit(enc_i(-7, 0, 0, 1, 7'h13));
        emit(enc_i(13, 0, 0, 2, 7'h13));
        for (int f3 = 0; f3 < 8; f3++) begin
            emit(enc_r(0, 2, 1, f3, 3));
            emit_store(3);
            if (f3 == 0 || f3 == 5) begin
                emit(enc_r(7'h20, 2, 1, f3, 3)); // sub, sra
                emit_store(3);
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 1) begin
                emit(enc_i(3, 1, f3, 3, 7'h13));
            end else if (f3 == 5) begin
                emit(enc_i(5, 1, f3, 3, 7'h13));
                emit_store(3);
                emit(enc_i(32'h402, 1, f3, 3, 7'h13)); // srai
            end else begin
                emit(enc_i(f3 * 37 - 100, 1, f3, 3, 7'h13));
            end
            emit_store(3);
        end
        emit(enc_i(5, 1, 0, 0, 7'h13)); // write to x0 is dropped
        emit_store(0);
        emit({20'habcde, 5'd4, 7'h37});
        emit_store(4);
        emit({20'h00012, 5'd4, 7'h17});
        emit_store(4);
        emit(enc_i(0, 0, 0, 9, 7'h13));
        emit(enc_j(8, 5));              // skips the next word
        emit(enc_i(2, 0, 0, 9, 7'h13));
        emit_store(5);
        emit_store(9);
        emit({20'h0, 5'd7, 7'h17});
        emit(enc_i(12, 7, 0, 8, 7'h67)); // jalr x8, 12(x7)
        emit(enc_i(1, 0, 0, 9, 7'h13));
        emit_store(8);
        emit_store(9);
        for (int k = 0; k < 12; k++) begin
            emit(enc_i(0, 0, 0, 11, 7'h13));
            emit(enc_b(8, br_rs2[k], br_rs1[k], br_f3[k]));
            emit(enc_i(1, 11, 0, 11, 7'h13)); // marker for the fall-through path
            emit_store(11);
        end
        emit(32'h1234_5e0b);                 // custom opcode treated as a no-op
        emit(enc_i(55, 0, 0, 3, 7'h13));
        emit_store(3);
        emit(enc_i(1024, 0, 0, 12, 7'h13));
        for (int k = 0; k < 4; k++) begin
            emit(enc_i(k * 4, 12, 2, 13, 7'h03));
            emit_store(13);
        end
        emit(enc_i(1, 0, 0, 14, 7'h13));
        emit(enc_s(2044, 14, 10));           // mailbox at 0xffc
    endtask

    // instruction-set model that fills the expected store queues
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] pc, npc, ins, a, b, bo, r, ii, si, bi, ji, addr;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic        wr, alt, taken, done;

        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = '0;
        done = 1'b0;
        for (int step = 0; step < 5000 && !done; step++) begin
            ins = ref_mem[pc[11:2]];
            op = ins[6:0];
            f3 = ins[14:12];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            ii = {{20{ins[31]}}, ins[31:20]};
            si = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            bi = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            ji = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc = pc + 32'd4;
            wr = 1'b0;
            r = '0;
            case (op)
                7'h33, 7'h13: begin
                    bo = (op == 7'h33) ? b : ii;
                    alt = ins[30] && (op == 7'h33 || f3 == 3'd5);
                    case (f3)
                        3'd0: r = alt ? a - bo : a + bo;
                        3'd1: r = a << bo[4:0];
                        3'd2: r = ($signed(a) < $signed(bo)) ? 32'd1 : 32'd0;
                        3'd3: r = (a < bo) ? 32'd1 : 32'd0;
                        3'd4: r = a ^ bo;
                        3'd5: begin
                            if (alt) begin
                                r = $signed(a) >>> bo[4:0]; // sign bit shifted in
                            end else begin
                                r = a >> bo[4:0];
                            end
                        end
                        3'd6: r = a | bo;
                        default: r = a & bo;
                    endcase
                    wr = 1'b1;
                end
                7'h37: begin
                    r = {ins[31:12], 12'b0};
                    wr = 1'b1;
                end
                7'h17: begin
                    r = pc + {ins[31:12], 12'b0};
                    wr = 1'b1;
                end
                7'h6f: begin
                    r = pc + 32'd4;
                    npc = pc + ji;
                    wr = 1'b1;
                end
                7'h67: begin
                    r = pc + 32'd4;
                    npc = (a + ii) & ~32'd1;
                    wr = 1'b1;
                end
                7'h63: begin
                    case (f3)
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = $signed(a) < $signed(b);
                        3'd5: taken = $signed(a) >= $signed(b);
                        3'd6: taken = a < b;
                        3'd7: taken = a >= b;
                        default: taken = 1'b0;
                    endcase
                    if (taken) npc = pc + bi;
                end
                7'h03: begin
                    addr = a + ii;
                    r = ref_mem[addr[11:2]];
                    wr = 1'b1;
                end
                7'h23: begin
                    addr = a + si;
                    ref_mem[addr[11:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    done = (addr == 32'hffc);
                end
                default: ; // unknown opcode
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
            pc = npc;
        end
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // memory model with random wait states
    initial begin
        logic        done_flag;
        logic        busy;
        logic        first_seen;
        logic        held_we;
        logic [31:0] held_addr;
        int          wait_cnt;

        mem_ready = 1'b0;
        mem_rdata = '0;
        seed = 32'he1b9_2bc4;
        busy = 1'b0;
        first_seen = 1'b0;
        held_we = 1'b0;
        held_addr = '0;
        wait_cnt = 0;
        forever begin
            @(negedge clk);
            done_flag = 1'b0;
            if (busy) begin
                check_value(32'(mem_valid), 32'd1, "valid while stalled");
                check_value(mem_addr, held_addr, "address while stalled");
                check_value(32'(mem_we), 32'(held_we), "write enable while stalled");
            end
            if (mem_valid && mem_ready) begin
                done_flag = 1'b1;
                if (mem_we) begin
                    mem[mem_addr[11:2]] = mem_wdata;
                    obs_addr.push_back(mem_addr);
                    obs_data.push_back(mem_wdata);
                end
            end
            @(posedge clk);
            #2;
            if (done_flag) begin
                busy = 1'b0;
                mem_ready = 1'b0;
            end
            if (mem_valid && !busy) begin
                if (!first_seen) begin
                    check_value(mem_addr, 32'h0, "first request address");
                    check_value(32'(mem_we), 32'd0, "first request write enable");
                    first_seen = 1'b1;
                end
                busy = 1'b1;
                wait_cnt = {$random(seed)} % 4;
                held_addr = mem_addr;
                held_we = mem_we;
            end
            if (busy) begin
                if (wait_cnt == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = mem[held_addr[11:2]];
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // compares every store of the DUT with the model
    initial begin
        int waited;

        arst_n = 1'b0;
        build_program();
        ref_mem = mem;
        run_reference();
        repeat (16) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int n = 0; n < exp_addr.size(); n++) begin
            waited = 0;
            while (obs_addr.size() == 0) begin
                @(negedge clk);
                waited++;
                if (waited > 2000) begin
                    $display("timeout: store %0d did not arrive within 2000 cycles", n);
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "store wait expired");
                end
            end
            check_value(obs_addr.pop_front(), exp_addr[n], "store address");
            check_value(obs_data.pop_front(), exp_data[n], "store data");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rv_core_asserts.sv
`default_nettype none

module rv_core_asserts (
    input logic            clk,
    input logic            arst_n,
    input rv_pkg::state_t  state,
    input logic            mem_valid,
    input logic            mem_we,
    input logic            mem_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    // no request while idle or in reset
    idle_quiet: assert property (@(posedge clk) state == st_idle |-> !mem_valid && !mem_we)
        else $error("memory request in st_idle");

    // a stalled request stays up in the same direction
    stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_we))
        else $error("memory request changed while stalled");

    wait_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (state inside {st_fetch, st_mem_read, st_mem_write}) && !mem_ready
            |=> state == $past(state))
        else $error("fsm left a memory state without mem_ready");

endmodule

bind rv_main_fsm rv_core_asserts fsm_asserts_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .state     (state),
    .mem_valid (mem_valid),
    .mem_we    (mem_we),
    .mem_ready (mem_ready)
);

`default_nettype wire

// File: src/rv_core.sv
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output logic                    mem_we,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    input  logic [rv_pkg::xlen-1:0] mem_rdata
);

    rv_ctrl_if ctrl_bus ();

    // sequencing and control decode
    rv_main_fsm fsm_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl_bus.ctrl),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_ready (mem_ready)
    );

    rv_datapath #(
        .reset_vector (reset_vector)
    ) datapath_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .dp        (ctrl_bus.dp),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: src/rv_datapath.sv
`default_nettype none

module rv_datapath #(
    parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    rv_ctrl_if.dp                   dp,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    input  logic [rv_pkg::xlen-1:0] mem_rdata
);
    import rv_pkg::*;

    logic [xlen-1:0] pc, old_pc, instr;
    logic [xlen-1:0] rs1_buf, rs2_buf, alu_out, data;
    logic [xlen-1:0] rdata1, rdata2, imm;
    logic [xlen-1:0] src_a, src_b, alu_result, result, pc_next;
    logic            funct7b5;

    assign dp.op = opcode_t'(instr[6:0]);

    // bit 30 selects sub/sra, but for op_imm only on the shifts
    assign funct7b5 = instr[30] && (dp.op == opc_op || instr[14:12] == 3'b101);

    always_comb begin
        unique case (dp.alu_src_a)
            src_a_pc:     src_a = pc;
            src_a_old_pc: src_a = old_pc;
            src_a_rs1:    src_a = rs1_buf;
            default:      src_a = '0;
        endcase
        unique case (dp.alu_src_b)
            src_b_rs2:  src_b = rs2_buf;
            src_b_imm:  src_b = imm;
            src_b_four: src_b = xlen'(4);
            default:    src_b = '0;
        endcase
        unique case (dp.result_src)
            result_alu_out: result = alu_out;
            result_data:    result = data;
            result_alu:     result = alu_result;
            default:        result = alu_out;
        endcase
    end

    // jumps and taken branches load the stored target, lsb cleared for jalr
    assign pc_next   = dp.branch ? {alu_out[xlen-1:1], 1'b0} : result;
    assign mem_addr  = (dp.adr_src == adr_result) ? result : pc;
    assign mem_wdata = rs2_buf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_vector;
        end else if (dp.pc_update) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.ir_write) begin
            old_pc <= pc;
            instr  <= mem_rdata;
        end
        rs1_buf <= rdata1;
        rs2_buf <= rdata2;
        alu_out <= alu_result;
        data    <= mem_rdata;
    end

    rv_regfile regfile_inst (
        .clk    (clk),
        .rs1    (instr[19:15]),
        .rs2    (instr[24:20]),
        .rd     (instr[11:7]),
        .we     (dp.reg_write),
        .wdata  (result),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_imm_gen imm_gen_inst (
        .instr    (instr),
        .imm_type (dp.imm_type),
        .imm      (imm)
    );

    rv_alu alu_inst (
        .a           (src_a),
        .b           (src_b),
        .alu_op      (dp.alu_op),
        .funct3      (instr[14:12]),
        .funct7b5    (funct7b5),
        .result      (alu_result),
        .take_branch (dp.take_branch)
    );

endmodule

`default_nettype wire

// File: src/rv_main_fsm.sv
`default_nettype none

module rv_main_fsm (
    input  logic   clk,
    input  logic   arst_n,
    rv_ctrl_if.ctrl ctrl,
    output logic   mem_valid,
    output logic   mem_we,
    input  logic   mem_ready
);
    import rv_pkg::*;

    state_t    state;
    state_t    next_state;
    imm_type_t mem_imm;

    // loads use the i format offset, stores the s format
    assign mem_imm = (ctrl.op == opc_store) ? imm_s : imm_i;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_fetch;
        unique case (state)
            st_idle:   next_state = st_fetch;
            st_fetch:  next_state = mem_ready ? st_decode : st_fetch;
            st_decode: begin
                case (ctrl.op)
                    opc_load, opc_store: next_state = st_mem_addr;
                    opc_op:              next_state = st_exec_r;
                    opc_op_imm:          next_state = st_exec_i;
                    opc_jal:             next_state = st_jal;
                    opc_jalr:            next_state = st_jalr;
                    opc_branch:          next_state = st_branch;
                    opc_lui:             next_state = st_lui;
                    opc_auipc:           next_state = st_auipc;
                    default:             next_state = st_fetch; // unknown op, skip it
                endcase
            end
            st_mem_addr:  next_state = (ctrl.op == opc_store) ? st_mem_write : st_mem_read;
            st_mem_read:  next_state = mem_ready ? st_mem_wb : st_mem_read;
            st_mem_wb:    next_state = st_fetch;
            st_mem_write: next_state = mem_ready ? st_fetch : st_mem_write;
            st_exec_r, st_exec_i, st_lui, st_auipc: next_state = st_alu_wb;
            st_alu_wb:    next_state = st_fetch;
            st_jalr:      next_state = st_jal; // link and jump share the jal state
            st_jal:       next_state = st_fetch;
            st_branch:    next_state = st_fetch;
            default:      next_state = st_fetch;
        endcase
    end

    always_comb begin
        ctrl.adr_src    = adr_pc;
        ctrl.ir_write   = 1'b0;
        ctrl.alu_src_a  = src_a_pc;
        ctrl.alu_src_b  = src_b_rs2;
        ctrl.alu_op     = alu_add;
        ctrl.imm_type   = imm_none;
        ctrl.result_src = result_alu_out;
        ctrl.pc_update  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.reg_write  = 1'b0;
        mem_valid       = 1'b0;
        mem_we          = 1'b0;

        unique case (state)
            st_fetch: begin
                // instr <- mem[pc], pc <- pc + 4
                mem_valid       = 1'b1;
                ctrl.ir_write   = mem_ready;
                ctrl.alu_src_b  = src_b_four;
                ctrl.result_src = result_alu;
                ctrl.pc_update  = mem_ready;
            end
            st_decode: begin
                // jump / branch target into alu_out
                ctrl.alu_src_a = src_a_old_pc;
                ctrl.alu_src_b = src_b_imm;
                case (ctrl.op)
                    opc_branch: ctrl.imm_type = imm_b;
                    opc_jal:    ctrl.imm_type = imm_j;
                    default:    ctrl.imm_type = imm_i;
                endcase
            end
            st_mem_addr, st_mem_read, st_mem_write: begin
                // address recomputed every cycle, so alu_out holds steady
                ctrl.alu_src_a  = src_a_rs1;
                ctrl.alu_src_b  = src_b_imm;
                ctrl.imm_type   = mem_imm;
                ctrl.adr_src    = adr_result;
                mem_valid       = (state != st_mem_addr);
                mem_we          = (state == st_mem_write);
            end
            st_mem_wb: begin
                ctrl.result_src = result_data;
                ctrl.reg_write  = 1'b1;
            end
            st_exec_r: begin
                ctrl.alu_src_a = src_a_rs1;
                ctrl.alu_op    = alu_arith_logic;
            end
            st_exec_i: begin
                ctrl.alu_src_a = src_a_rs1;
                ctrl.alu_src_b = src_b_imm;
                ctrl.alu_op    = alu_arith_logic;
                ctrl.imm_type  = imm_i;
            end
            st_lui, st_auipc: begin
                ctrl.alu_src_a = src_a_old_pc; // ignored for lui
                ctrl.alu_src_b = src_b_imm;
                ctrl.alu_op    = (state == st_lui) ? alu_lui : alu_auipc;
                ctrl.imm_type  = imm_u;
            end
            st_alu_wb:
                ctrl.reg_write = 1'b1;
            st_jalr: begin
                ctrl.alu_src_a = src_a_rs1;
                ctrl.alu_src_b = src_b_imm;
                ctrl.imm_type  = imm_i;
            end
            st_jal: begin
                // pc <- alu_out, rd <- old_pc + 4
                ctrl.alu_src_a  = src_a_old_pc;
                ctrl.alu_src_b  = src_b_four;
                ctrl.result_src = result_alu;
                ctrl.reg_write  = 1'b1;
                ctrl.pc_update  = 1'b1;
                ctrl.branch     = 1'b1;
            end
            st_branch: begin
                ctrl.alu_src_a = src_a_rs1;
                ctrl.alu_op    = alu_branch;
                ctrl.branch    = 1'b1;
                ctrl.pc_update = ctrl.take_branch; // only jump when the compare holds
            end
            default: ; // idle, everything inactive
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_imm_gen.sv
`default_nettype none

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::imm_type_t       imm_type,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            imm_i: imm = {{20{sign}}, instr[31:20]};
            imm_s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            imm_b: imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_u: imm = {instr[31:12], 12'b0}; // already shifted
            imm_j: imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0; // imm_none
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin // x0 never written
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: src/rv_alu.sv
`default_nettype none

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [2:0]              funct3,
    input  logic                    funct7b5,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    take_branch
);
    import rv_pkg::*;

    logic cond;

    always_comb begin
        result = a + b;
        unique case (alu_op)
            alu_add, alu_auipc: result = a + b;
            alu_lui:            result = b;
            alu_branch:         result = a - b;
            alu_arith_logic: begin
                unique case (funct3)
                    3'b000: result = funct7b5 ? a - b : a + b;
                    3'b001: result = a << b[4:0];
                    3'b010: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
                    3'b011: result = {{(xlen-1){1'b0}}, a < b};
                    3'b100: result = a ^ b;
                    3'b101: result = funct7b5 ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110: result = a | b;
                    3'b111: result = a & b;
                endcase
            end
            default: result = a + b;
        endcase
    end

    // branch compare by funct3
    always_comb begin
        case (funct3)
            3'b000:  cond = (a == b);
            3'b001:  cond = (a != b);
            3'b100:  cond = $signed(a) < $signed(b);
            3'b101:  cond = $signed(a) >= $signed(b);
            3'b110:  cond = a < b;
            3'b111:  cond = a >= b;
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = (alu_op == alu_branch) && cond;

endmodule

`default_nettype wire

// File: src/rv_ctrl_if.sv
`default_nettype none

interface rv_ctrl_if;
    import rv_pkg::*;

    adr_src_t    adr_src;
    logic        ir_write;
    src_a_t      alu_src_a;
    src_b_t      alu_src_b;
    alu_op_t     alu_op;
    imm_type_t   imm_type;
    result_src_t result_src;
    logic        pc_update;
    logic        branch;     // pc takes the stored target from alu_out
    logic        reg_write;

    opcode_t     op;          // opcode of the instruction register
    logic        take_branch; // compare result of the alu

    modport ctrl (
        output adr_src, ir_write, alu_src_a, alu_src_b, alu_op, imm_type,
        output result_src, pc_update, branch, reg_write,
        input  op, take_branch
    );

    modport dp (
        input  adr_src, ir_write, alu_src_a, alu_src_b, alu_op, imm_type,
        input  result_src, pc_update, branch, reg_write,
        output op, take_branch
    );

endinterface

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opc_load   = 7'b000_0011,
        opc_store  = 7'b010_0011,
        opc_op     = 7'b011_0011,
        opc_op_imm = 7'b001_0011,
        opc_jal    = 7'b110_1111,
        opc_jalr   = 7'b110_0111,
        opc_branch = 7'b110_0011,
        opc_lui    = 7'b011_0111,
        opc_auipc  = 7'b001_0111
    } opcode_t;

    typedef enum logic [3:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_mem_addr,
        st_mem_read,
        st_mem_wb,
        st_mem_write,
        st_exec_r,
        st_exec_i,
        st_alu_wb,
        st_jal,
        st_jalr,
        st_branch,
        st_lui,
        st_auipc
    } state_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_arith_logic, // funct3 / funct7 bit 5 pick the operation
        alu_branch,      // funct3 picks the compare
        alu_lui,
        alu_auipc
    } alu_op_t;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j, imm_none} imm_type_t;

    typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1} src_a_t;

    typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_t;

    typedef enum logic [1:0] {result_alu_out, result_data, result_alu} result_src_t;

    typedef enum logic {adr_pc, adr_result} adr_src_t;

endpackage

`default_nettype wire
